//--- design/bus_protect.sv
module bus_protect (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  logic                                vcheck_i,
  input  logic [wbs_arb_pkg::ADR_W-1:0]       adr_i,
  input  logic                                we_i,
  input  logic [wbs_arb_pkg::NUM_MASTERS-1:0] wbm_id_i,
  output logic                                vpass_o,
  output logic                                vfail_o
);
  import wbs_arb_pkg::*;

  logic [NUM_RESTRICT-1:0] hit;     // address inside the region.
  logic [NUM_RESTRICT-1:0] denied;  // region refuses this master and direction.
  logic                    fail;

  // all regions are checked in parallel.
  always_comb begin
    for (int r = 0; r < NUM_RESTRICT; r++) begin
      hit[r]    = (adr_i >= RESTRICT_MAP[r].base) && (adr_i <= RESTRICT_MAP[r].high);
      denied[r] = ~|(RESTRICT_MAP[r].mask & wbm_id_i) &&
                  (we_i ? RESTRICT_MAP[r].protect_wr : RESTRICT_MAP[r].protect_rd);
    end
  end

  assign fail = |(hit & denied);

  // one pulse, pass or fail, the cycle after the check strobe.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      vpass_o <= 1'b0;
      vfail_o <= 1'b0;
    end else begin
      vpass_o <= vcheck_i & ~fail;
      vfail_o <= vcheck_i & fail;
    end
  end

endmodule

//--- design/bus_timeout.sv
module bus_timeout (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          clear_i,
  input  logic [wbs_arb_pkg::ADR_W-1:0] adr_i,
  output logic                          timeout_o
);
  import wbs_arb_pkg::*;

  logic [TO_W-1:0] limit;
  logic [TO_W-1:0] count;

  // first matching entry sets the limit.
  always_comb begin
    limit = TO_DEFAULT;
    for (int i = NUM_TOCONF - 1; i >= 0; i--) begin  // walk down so entry 0 wins.
      if (adr_i >= TOCONF_MAP[i].base && adr_i <= TOCONF_MAP[i].high) begin
        limit = TOCONF_MAP[i].limit;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      count     <= '0;
      timeout_o <= 1'b0;
    end else if (count == limit) begin
      timeout_o <= 1'b1;  // count stops here, flag held.
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- design/wbs_arb_pkg.sv
package wbs_arb_pkg;

  localparam int ADR_W        = 16;
  localparam int DAT_W        = 16;
  localparam int NUM_MASTERS  = 4;   // width of the one-hot master id.
  localparam int NUM_SLAVES   = 4;
  localparam int NUM_RESTRICT = 3;
  localparam int NUM_TOCONF   = 2;
  localparam int PAGE_LSB     = 6;   // windows are 64-byte aligned.
  localparam int TO_W         = 20;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat;
  } wbm_req_t;

  typedef struct packed {
    logic [DAT_W-1:0] dat;
    logic             ack;
    logic             err;
  } wbm_rsp_t;

  // slave side, cyc and stb are one-hot per slave.
  typedef struct packed {
    logic [NUM_SLAVES-1:0] cyc;
    logic [NUM_SLAVES-1:0] stb;
    logic                  we;
    logic [ADR_W-1:0]      adr;
    logic [DAT_W-1:0]      dat;
  } wbs_req_t;

  typedef struct packed {
    logic                   memv;
    logic [NUM_MASTERS-1:0] wbm_id;
    logic [ADR_W-1:0]       addr;
    logic                   we;
    logic                   timeout;
  } bm_report_t;

  typedef struct packed {
    logic [ADR_W-1:0] base;
    logic [ADR_W-1:0] high;
  } window_t;

  typedef struct packed {
    logic [ADR_W-1:0]       base;
    logic [ADR_W-1:0]       high;
    logic [NUM_MASTERS-1:0] mask;        // masters allowed in.
    logic                   protect_rd;
    logic                   protect_wr;
  } restrict_t;

  typedef struct packed {
    logic [ADR_W-1:0] base;
    logic [ADR_W-1:0] high;
    logic [TO_W-1:0]  limit;
  } toconf_t;

  localparam window_t SLAVE_MAP [NUM_SLAVES] = '{
    '{base: 16'h0000, high: 16'h03ff},
    '{base: 16'h0400, high: 16'h07ff},
    '{base: 16'h1000, high: 16'h10ff},
    '{base: 16'h2000, high: 16'h203f}
  };

  // base above high leaves an entry empty.
  localparam restrict_t RESTRICT_MAP [NUM_RESTRICT] = '{
    '{base: 16'h0000, high: 16'h00ff, mask: 4'b0001, protect_rd: 1'b0, protect_wr: 1'b1},
    '{base: 16'h1000, high: 16'h10ff, mask: 4'b0011, protect_rd: 1'b1, protect_wr: 1'b1},
    '{base: 16'hffff, high: 16'h0000, mask: 4'b0000, protect_rd: 1'b0, protect_wr: 1'b0}
  };

  localparam toconf_t TOCONF_MAP [NUM_TOCONF] = '{
    '{base: 16'h2000, high: 16'h203f, limit: 20'd40},
    '{base: 16'hffff, high: 16'h0000, limit: 20'd0}
  };

  localparam logic [TO_W-1:0] TO_DEFAULT = 20'd16;

endpackage

//--- design/wbs_arbiter.sv
module wbs_arbiter (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  wbs_arb_pkg::wbm_req_t               wbm_req_i,
  input  logic [wbs_arb_pkg::NUM_MASTERS-1:0] wbm_id_i,
  output wbs_arb_pkg::wbm_rsp_t               wbm_rsp_o,
  output wbs_arb_pkg::wbs_req_t               wbs_req_o,
  input  logic [wbs_arb_pkg::NUM_SLAVES-1:0][wbs_arb_pkg::DAT_W-1:0] wbs_dat_i,
  input  logic [wbs_arb_pkg::NUM_SLAVES-1:0]  wbs_ack_i,
  output wbs_arb_pkg::bm_report_t             bm_report_o
);
  import wbs_arb_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_CHECK,
    S_WAIT
  } state_t;

  state_t state;

  logic [NUM_SLAVES-1:0]  slave_sel;   // decoded from the live address.
  logic [NUM_SLAVES-1:0]  active_q;    // latched at the start of a cycle.
  logic [NUM_SLAVES-1:0]  slv_en_q;    // drives slave cyc and stb.
  logic [ADR_W-1:0]       adr_q;
  logic [DAT_W-1:0]       dat_q;
  logic                   we_q;
  logic [NUM_MASTERS-1:0] id_q;
  logic [ADR_W-1:0]       slv_adr;
  logic [DAT_W-1:0]       rdata;
  logic [DAT_W-1:0]       rdat_q;
  logic                   ack_q;
  logic                   err_q;
  logic                   memv_q;
  logic                   to_q;
  logic                   vcheck_q;
  logic                   vpass;
  logic                   vfail;
  logic                   timeout;

  // lowest-numbered window wins, compared on page bits only.
  always_comb begin
    slave_sel = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if (wbm_req_i.adr[ADR_W-1:PAGE_LSB] >= SLAVE_MAP[i].base[ADR_W-1:PAGE_LSB] &&
          wbm_req_i.adr[ADR_W-1:PAGE_LSB] <= SLAVE_MAP[i].high[ADR_W-1:PAGE_LSB]) begin
        slave_sel    = '0;
        slave_sel[i] = 1'b1;
      end
    end
  end

  // rebase to the active window and pick its read data.
  always_comb begin
    slv_adr = '0;
    rdata   = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (active_q[i]) begin
        slv_adr = adr_q - SLAVE_MAP[i].base;
        rdata   = wbs_dat_i[i];
      end
    end
  end

  bus_protect u_protect (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .vcheck_i (vcheck_q),
    .adr_i    (adr_q),
    .we_i     (we_q),
    .wbm_id_i (id_q),
    .vpass_o  (vpass),
    .vfail_o  (vfail)
  );

  bus_timeout u_timeout (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .clear_i   (state != S_WAIT),  // counts only while a slave is pending.
    .adr_i     (adr_q),
    .timeout_o (timeout)
  );

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state    <= S_IDLE;
      active_q <= '0;
      slv_en_q <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      memv_q   <= 1'b0;
      to_q     <= 1'b0;
      vcheck_q <= 1'b0;
    end else begin
      ack_q    <= 1'b0;  // response flags are single pulses.
      err_q    <= 1'b0;
      memv_q   <= 1'b0;
      to_q     <= 1'b0;
      vcheck_q <= 1'b0;
      case (state)
        S_IDLE: begin
          // skip the response cycle, stb is still up from the last request.
          if (wbm_req_i.cyc && wbm_req_i.stb && !ack_q && !err_q) begin
            active_q <= slave_sel;
            vcheck_q <= 1'b1;
            state    <= S_CHECK;
          end
        end
        S_CHECK: begin
          if (vfail) begin
            err_q  <= 1'b1;
            memv_q <= 1'b1;
            state  <= S_IDLE;
          end else if (vpass && active_q == '0) begin
            err_q <= 1'b1;  // unmapped.
            state <= S_IDLE;
          end else if (vpass) begin
            slv_en_q <= active_q;
            state    <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (|(wbs_ack_i & active_q)) begin
            slv_en_q <= '0;
            ack_q    <= 1'b1;
            state    <= S_IDLE;
          end else if (timeout) begin
            slv_en_q <= '0;
            err_q    <= 1'b1;
            to_q     <= 1'b1;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request and read data payload.
  always_ff @(posedge wb_clk_i) begin
    if (state == S_IDLE) begin
      adr_q <= wbm_req_i.adr;
      dat_q <= wbm_req_i.dat;
      we_q  <= wbm_req_i.we;
      id_q  <= wbm_id_i;
    end
    if (state == S_WAIT) begin
      rdat_q <= rdata;
    end
  end

  assign wbs_req_o.cyc = slv_en_q;
  assign wbs_req_o.stb = slv_en_q;
  assign wbs_req_o.we  = we_q;
  assign wbs_req_o.adr = slv_adr;
  assign wbs_req_o.dat = dat_q;

  assign wbm_rsp_o.dat = rdat_q;
  assign wbm_rsp_o.ack = ack_q;
  assign wbm_rsp_o.err = err_q;

  assign bm_report_o.memv    = memv_q;
  assign bm_report_o.wbm_id  = id_q;
  assign bm_report_o.addr    = adr_q;
  assign bm_report_o.we      = we_q;
  assign bm_report_o.timeout = to_q;

endmodule

//--- filelist.f
design/wbs_arb_pkg.sv
design/bus_protect.sv
design/bus_timeout.sv
design/wbs_arbiter.sv
tb/wbs_slave_model.sv
tb/tb_wbs_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# build and run the arbiter testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module tb_wbs_arbiter -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vtb_wbs_arbiter > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

# the log decides the result.
if grep -q "FAIL: see errors above" "$SIM_LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0

//--- tb/tb_wbs_arbiter.sv
module tb_wbs_arbiter;
  timeunit 1ns;
  timeprecision 1ps;
  import wbs_arb_pkg::*;

  localparam int WAIT_MAX = 100;  // cycles allowed for ack or err.

  typedef enum logic [1:0] {OUT_ACK, OUT_VIOL, OUT_UNMAP, OUT_TMO} outcome_t;

  typedef struct packed {
    logic [NUM_MASTERS-1:0] id;
    logic                   we;
    logic [ADR_W-1:0]       adr;
    logic [DAT_W-1:0]       wdat;
    logic [3:0]             delay;
    logic                   silent;
    outcome_t               outcome;
    logic [1:0]             slave;
    logic [DAT_W-1:0]       rdat;
  } row_t;

  // the slave sees the address minus its window base.
  localparam logic [ADR_W-1:0] WIN_BASE [NUM_SLAVES] = '{16'h0000, 16'h0400, 16'h1000, 16'h2000};

  logic                             wb_clk_i;
  logic                             wb_rst_i;
  wbm_req_t                         wbm_req;
  logic [NUM_MASTERS-1:0]           wbm_id;
  wbm_rsp_t                         wbm_rsp;
  wbs_req_t                         wbs_req;
  logic [NUM_SLAVES-1:0][DAT_W-1:0] wbs_dat;
  logic [NUM_SLAVES-1:0]            wbs_ack;
  bm_report_t                       report;
  logic [3:0]                       delay;
  logic                             silent;

  row_t             rows[$];
  logic [DAT_W-1:0] shadow [logic [ADR_W-1:0]];  // last acked write per address.
  int               tmo_cycles [NUM_SLAVES];

  always #4 wb_clk_i = ~wb_clk_i;

  wbs_arbiter uut (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wbm_req_i   (wbm_req),
    .wbm_id_i    (wbm_id),
    .wbm_rsp_o   (wbm_rsp),
    .wbs_req_o   (wbs_req),
    .wbs_dat_i   (wbs_dat),
    .wbs_ack_i   (wbs_ack),
    .bm_report_o (report)
  );

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
    wbs_slave_model #(.FILL(16'(16'h0a5a + s * 16'h1000))) u_mem (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc_i    (wbs_req.cyc[s]),
      .stb_i    (wbs_req.stb[s]),
      .we_i     (wbs_req.we),
      .adr_i    (wbs_req.adr),
      .dat_i    (wbs_req.dat),
      .delay_i  (delay),
      .silent_i (silent),
      .dat_o    (wbs_dat[s]),
      .ack_o    (wbs_ack[s])
    );
  end

  function automatic void add_row(input int m, input logic we, input logic [ADR_W-1:0] adr,
                                  input int dly, input logic quiet, input outcome_t outcome,
                                  input int slave);
    row_t r;
    r.id      = 4'b0001 << m;
    r.we      = we;
    r.adr     = adr;
    r.wdat    = we ? 16'($urandom) : '0;
    r.delay   = 4'(dly);
    r.silent  = quiet;
    r.outcome = outcome;
    r.slave   = 2'(slave);
    r.rdat    = '0;
    if (outcome == OUT_ACK && we)
      shadow[adr] = r.wdat;
    else if (outcome == OUT_ACK && shadow.exists(adr))
      r.rdat = shadow[adr];  // reads expect the earlier write.
    rows.push_back(r);
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  task automatic check_rsp(input wbm_rsp_t got, input wbm_rsp_t exp, input logic with_dat,
                           input string what);
    if (got.ack !== exp.ack || got.err !== exp.err || (with_dat && got.dat !== exp.dat))
      report_mismatch($sformatf("%s: response %h, expected %h", what, got, exp));
  endtask

  task automatic check_report(input bm_report_t got, input bm_report_t exp,
                              input logic with_fields, input string what);
    if (got.memv !== exp.memv || got.timeout !== exp.timeout ||
        (with_fields && {got.wbm_id, got.addr, got.we} !== {exp.wbm_id, exp.addr, exp.we}))
      report_mismatch($sformatf("%s: monitor report %h, expected %h", what, got, exp));
  endtask

  task automatic check_slave_req(input wbs_req_t got, input wbs_req_t exp,
                                 input logic with_payload, input string what);
    if (got.cyc !== exp.cyc || got.stb !== exp.stb ||
        (with_payload && {got.we, got.adr, got.dat} !== {exp.we, exp.adr, exp.dat}))
      report_mismatch($sformatf("%s: slave request %h, expected %h", what, got, exp));
  endtask

  task automatic check_reset_state(input string what);
    check_slave_req(wbs_req, '0, 1'b0, what);
    check_rsp(wbm_rsp, '0, 1'b0, what);
    check_report(report, '0, 1'b0, what);
  endtask

  task automatic run_row(input row_t r, input int n);
    wbm_rsp_t   exp_rsp;
    bm_report_t exp_rep;
    wbs_req_t   exp_sreq;
    logic       fwd;
    logic       strobed;
    logic       done;
    int         cycles;
    string      what;
    what          = $sformatf("row %0d", n);
    fwd           = (r.outcome == OUT_ACK) || (r.outcome == OUT_TMO);
    exp_sreq.cyc  = fwd ? (4'b0001 << r.slave) : 4'b0000;
    exp_sreq.stb  = exp_sreq.cyc;
    exp_sreq.we   = r.we;
    exp_sreq.adr  = r.adr - WIN_BASE[r.slave];
    exp_sreq.dat  = r.wdat;
    exp_rsp.dat   = r.rdat;
    exp_rsp.ack   = (r.outcome == OUT_ACK);
    exp_rsp.err   = !exp_rsp.ack;
    exp_rep       = {r.outcome == OUT_VIOL, r.id, r.adr, r.we, r.outcome == OUT_TMO};
    @(posedge wb_clk_i);
    wbm_req <= '{cyc: 1'b1, stb: 1'b1, we: r.we, adr: r.adr, dat: r.wdat};
    wbm_id  <= r.id;
    delay   <= r.delay;
    silent  <= r.silent;
    strobed = 1'b0;
    done    = 1'b0;
    cycles  = 0;
    while (!done) begin
      @(negedge wb_clk_i);
      cycles++;
      if (|wbs_req.stb) begin
        check_slave_req(wbs_req, exp_sreq, 1'b1, what);
        strobed = 1'b1;
      end
      if (wbm_rsp.ack || wbm_rsp.err)
        done = 1'b1;
      else if (cycles >= WAIT_MAX)
        stop_run($sformatf("%s: no ack or err from the arbiter within %0d cycles",
                           what, WAIT_MAX));
    end
    if (fwd && !strobed)
      report_mismatch($sformatf("%s: request never reached slave %0d", what, r.slave));
    check_rsp(wbm_rsp, exp_rsp, !r.we && r.outcome == OUT_ACK, what);
    check_report(report, exp_rep, 1'b1, what);
    if (r.outcome == OUT_TMO)
      tmo_cycles[r.slave] = cycles;
    @(posedge wb_clk_i);
    wbm_req.cyc <= 1'b0;  // master drops the cycle after the response.
    wbm_req.stb <= 1'b0;
  endtask

  initial begin
    void'($urandom(99));
    wb_clk_i = 1'b0;
    wb_rst_i = 1'b1;
    wbm_req  = '0;
    wbm_id   = '0;
    delay    = '0;
    silent   = 1'b0;
    add_row(0, 1'b1, 16'h0040, 0, 1'b0, OUT_ACK, 0);
    add_row(2, 1'b1, 16'h0040, 0, 1'b0, OUT_VIOL, 0);
    add_row(1, 1'b1, 16'h0502, 2, 1'b0, OUT_ACK, 1);
    add_row(1, 1'b1, 16'h1000, 1, 1'b0, OUT_ACK, 2);
    add_row(2, 1'b1, 16'h2010, 3, 1'b0, OUT_ACK, 3);
    add_row(3, 1'b0, 16'h0040, 1, 1'b0, OUT_ACK, 0);
    add_row(0, 1'b0, 16'h0502, 3, 1'b0, OUT_ACK, 1);
    add_row(1, 1'b0, 16'h1000, 0, 1'b0, OUT_ACK, 2);
    add_row(3, 1'b0, 16'h1000, 0, 1'b0, OUT_VIOL, 2);
    add_row(2, 1'b0, 16'h2010, 2, 1'b0, OUT_ACK, 3);
    add_row(0, 1'b1, 16'h8000, 0, 1'b0, OUT_UNMAP, 0);
    add_row(0, 1'b0, 16'h0100, 0, 1'b1, OUT_TMO, 0);
    add_row(0, 1'b0, 16'h0040, 2, 1'b0, OUT_ACK, 0);  // timeout must have cleared.
    add_row(1, 1'b0, 16'h2020, 0, 1'b1, OUT_TMO, 3);
    add_row(3, 1'b1, 16'h07fe, 1, 1'b0, OUT_ACK, 1);
    for (int i = 0; i < 5; i++) begin
      @(posedge wb_clk_i);
      if (i == 4)
        wb_rst_i <= 1'b0;
      @(negedge wb_clk_i);
      check_reset_state("during reset");
    end
    @(negedge wb_clk_i);
    check_reset_state("after reset");
    foreach (rows[n]) begin
      run_row(rows[n], n);
    end
    if (tmo_cycles[3] <= tmo_cycles[0]) begin
      report_mismatch($sformatf("slave 3 timed out after %0d cycles, slave 0 after %0d",
                                tmo_cycles[3], tmo_cycles[0]));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

//--- tb/wbs_slave_model.sv
module wbs_slave_model #(
  parameter logic [15:0] FILL = 16'h0000
) (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          cyc_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [wbs_arb_pkg::ADR_W-1:0] adr_i,
  input  logic [wbs_arb_pkg::DAT_W-1:0] dat_i,
  input  logic [3:0]                    delay_i,   // cycles before ack.
  input  logic                          silent_i,  // never acks.
  output logic [wbs_arb_pkg::DAT_W-1:0] dat_o,
  output logic                          ack_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import wbs_arb_pkg::*;

  logic [DAT_W-1:0] mem [64];
  logic [3:0]       wait_cnt;
  logic [5:0]       idx;

  assign idx = adr_i[5:0];  // 64 words, upper bits alias.

  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o    <= 1'b0;
      wait_cnt <= '0;
      dat_o    <= '0;
      for (int i = 0; i < 64; i++) begin
        mem[i] <= FILL ^ 16'(i * 37);  // fill differs per word.
      end
    end else if (cyc_i && stb_i && !ack_o && !silent_i) begin
      if (wait_cnt == delay_i) begin
        ack_o    <= 1'b1;
        dat_o    <= mem[idx];
        wait_cnt <= '0;
        if (we_i) begin
          mem[idx] <= dat_i;
        end
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else begin
      ack_o    <= 1'b0;  // single-cycle ack.
      wait_cnt <= '0;
    end
  end

endmodule
